//--- logic/frame_rd_pkg.sv
// sizes, vector types, AXI read structs and reader states shared by every frame reader block
`default_nettype none

package frame_rd_pkg;

	// ------------------------------
	// bus and pixel sizes
	// ------------------------------
	localparam int addr_w = 32;
	localparam int beat_w = 128;
	localparam int pix_w = 32;
	// pixels per beat, lowest lane goes out first
	localparam int lanes = beat_w / pix_w;
	localparam int lane_w = $clog2(lanes);

	// fixed-length INCR bursts, 16 beats of 16 bytes
	localparam int burst_len = 16;
	localparam int burst_bytes = burst_len * beat_w / 8;
	localparam int axi_size = 4;
	localparam logic [1:0] burst_incr = 2'b01;

	// line FIFO holds four bursts
	localparam int fifo_depth = 64;
	localparam int fifo_aw = $clog2(fifo_depth);
	localparam int cnt_w = fifo_aw + 1;

	// quiet time after a frame start before the first request
	localparam int settle_cycles = 31;
	localparam int settle_w = $clog2(settle_cycles + 1);

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [beat_w-1:0] beat_t;
	typedef logic [pix_w-1:0] pix_t;
	typedef logic [lane_w-1:0] lane_t;
	typedef logic [fifo_aw-1:0] fifo_ptr_t;
	typedef logic [cnt_w-1:0] fifo_cnt_t;
	typedef logic [settle_w-1:0] settle_t;

	// read address channel, 45 bits
	typedef struct packed {
		addr_t addr;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ar_t;

	// read data channel, 131 bits
	typedef struct packed {
		beat_t data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	typedef enum logic [1:0] {rd_idle, rd_settle, rd_addr, rd_data} rd_state_e;

endpackage

`default_nettype wire

//--- logic/axi_burst_reader.sv
// AXI4 read master that restarts on vsync fall, settles, then fetches the frame burst by burst
`default_nettype none

module axi_burst_reader (
	input  wire                          axi_clk,
	input  wire                          r_rfifo_rst,
	input  wire frame_rd_pkg::addr_t     base_addr_i,
	input  wire frame_rd_pkg::addr_t     end_addr_i,
	input  wire                          vsync_i,
	input  wire                          arready_i,
	input  wire frame_rd_pkg::axi_r_t    r_i,
	input  wire                          rvalid_i,
	input  wire                          burst_room_i,
	output frame_rd_pkg::axi_ar_t        ar_o,
	output logic                         arvalid_o,
	output frame_rd_pkg::beat_t          beat_o,
	output logic                         beat_valid_o,
	output logic                         flush_o
);

	frame_rd_pkg::rd_state_e state_q;
	frame_rd_pkg::settle_t settle_q;
	// byte offset of the next burst inside the frame
	frame_rd_pkg::addr_t offset_q;
	// address held steady while arvalid is up
	frame_rd_pkg::addr_t ar_addr_q;
	frame_rd_pkg::addr_t next_addr;
	logic vsync_q;
	logic vsync_fall;
	// a burst is requested and its last beat not yet seen
	logic pend_q;
	// outstanding burst belongs to the previous frame
	logic stale_q;
	logic ar_fire;
	logic r_done;
	logic req_go;
	logic ar_load;

	// ------------------------------
	// frame start
	// ------------------------------
	assign vsync_fall = vsync_q & ~vsync_i;

	// flush comes one cycle after the edge is seen
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			vsync_q <= 1'b0;
			flush_o <= 1'b0;
		end else begin
			vsync_q <= vsync_i;
			flush_o <= vsync_fall;
		end
	end

	// ------------------------------
	// request control
	// ------------------------------
	assign ar_fire = arvalid_o & arready_i;
	// rready is tied high, so every rvalid beat is taken
	assign r_done = rvalid_i & r_i.last;
	assign next_addr = base_addr_i + offset_q;
	// room for a whole burst, window not exhausted, nothing in flight
	assign req_go = burst_room_i && (next_addr < end_addr_i) && !pend_q;
	assign ar_load = (state_q == frame_rd_pkg::rd_idle) && req_go && !flush_o;

	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			// reset behaves like a frame start
			state_q <= frame_rd_pkg::rd_settle;
			settle_q <= frame_rd_pkg::settle_t'(frame_rd_pkg::settle_cycles);
			arvalid_o <= 1'b0;
			pend_q <= 1'b0;
			stale_q <= 1'b0;
		end else begin
			// arvalid drops only on the handshake, even across a flush
			if (ar_fire) begin
				arvalid_o <= 1'b0;
			end
			if (r_done) begin
				pend_q <= 1'b0;
				stale_q <= 1'b0;
			end else if (flush_o && pend_q) begin
				stale_q <= 1'b1;
			end

			if (flush_o) begin
				state_q <= frame_rd_pkg::rd_settle;
				settle_q <= frame_rd_pkg::settle_t'(frame_rd_pkg::settle_cycles);
			end else begin
				case (state_q)
					frame_rd_pkg::rd_settle: begin
						if (settle_q == '0) begin
							state_q <= frame_rd_pkg::rd_idle;
						end else begin
							settle_q <= settle_q - 1'b1;
						end
					end
					frame_rd_pkg::rd_idle: begin
						if (ar_load) begin
							arvalid_o <= 1'b1;
							pend_q <= 1'b1;
							state_q <= frame_rd_pkg::rd_addr;
						end
					end
					frame_rd_pkg::rd_addr: begin
						// wait for the slave to take the address
						if (ar_fire) begin
							state_q <= frame_rd_pkg::rd_data;
						end
					end
					frame_rd_pkg::rd_data: begin
						// one burst outstanding, done on last
						if (r_done) begin
							state_q <= frame_rd_pkg::rd_idle;
						end
					end
					default: begin
						state_q <= frame_rd_pkg::rd_idle;
					end
				endcase
			end
		end
	end

	// offset restarts at the base on every frame
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			offset_q <= '0;
		end else if (flush_o) begin
			offset_q <= '0;
		end else if (ar_fire && !stale_q) begin
			offset_q <= offset_q + frame_rd_pkg::addr_t'(frame_rd_pkg::burst_bytes);
		end
	end

	always_ff @(posedge axi_clk) begin
		if (ar_load) begin
			ar_addr_q <= next_addr;
		end
	end

	assign ar_o = '{
		addr: ar_addr_q,
		len: 8'(frame_rd_pkg::burst_len - 1),
		size: 3'(frame_rd_pkg::axi_size),
		burst: frame_rd_pkg::burst_incr
	};

	// ------------------------------
	// beat forwarding
	// ------------------------------
	// beats of an old-frame burst are dropped here
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			beat_valid_o <= 1'b0;
		end else begin
			beat_valid_o <= rvalid_i && !stale_q && !flush_o;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (rvalid_i) begin
			beat_o <= r_i.data;
		end
	end

endmodule

`default_nettype wire

//--- logic/line_fifo.sv
// circular beat buffer between the AXI reader and the unpacker, with burst reservation and flush
`default_nettype none

module line_fifo (
	input  wire                          axi_clk,
	input  wire                          r_rfifo_rst,
	input  wire                          flush_i,
	input  wire frame_rd_pkg::beat_t     beat_i,
	input  wire                          beat_valid_i,
	input  wire                          word_ready_i,
	input  wire                          arvalid_i,
	input  wire                          arready_i,
	output logic                         burst_room_o,
	output frame_rd_pkg::beat_t          word_o,
	output logic                         word_valid_o
);

	frame_rd_pkg::beat_t mem [frame_rd_pkg::fifo_depth];
	frame_rd_pkg::fifo_ptr_t wr_ptr_q;
	frame_rd_pkg::fifo_ptr_t rd_ptr_q;
	frame_rd_pkg::fifo_cnt_t count_q;
	// entries promised to beats still on their way
	frame_rd_pkg::fifo_cnt_t resv_q;
	frame_rd_pkg::fifo_cnt_t free_room;
	// address pending at flush, its beats never arrive here
	logic cancel_q;
	logic push;
	logic pop;
	logic ar_fire;
	logic take_resv;

	assign push = beat_valid_i;
	assign pop = word_valid_o && word_ready_i;
	assign ar_fire = arvalid_i && arready_i;
	assign take_resv = ar_fire && !cancel_q;

	// ------------------------------
	// room check
	// ------------------------------
	// count plus reservations never exceeds the depth
	assign free_room = frame_rd_pkg::fifo_cnt_t'(frame_rd_pkg::fifo_depth) - count_q - resv_q;
	assign burst_room_o = free_room >= frame_rd_pkg::fifo_cnt_t'(frame_rd_pkg::burst_len);

	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			resv_q <= '0;
			cancel_q <= 1'b0;
		end else if (flush_i) begin
			resv_q <= '0;
			cancel_q <= arvalid_i && !arready_i;
		end else begin
			// one burst reserved per address, one entry released per beat
			resv_q <= resv_q
				+ (take_resv ? frame_rd_pkg::fifo_cnt_t'(frame_rd_pkg::burst_len) : '0)
				- frame_rd_pkg::fifo_cnt_t'(push && (resv_q != '0));
			if (ar_fire) begin
				cancel_q <= 1'b0;
			end
		end
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else if (flush_i) begin
			// flush wins over a write in the same cycle
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (push && !flush_i) begin
			mem[wr_ptr_q] <= beat_i;
		end
	end

	// head word is visible the cycle after its write
	assign word_o = mem[rd_ptr_q];
	assign word_valid_o = count_q != '0;

endmodule

`default_nettype wire

//--- logic/pixel_unpacker.sv
// splits each FIFO beat into four pixels on a valid/ready stream, lowest lane first
`default_nettype none

module pixel_unpacker (
	input  wire                          axi_clk,
	input  wire                          r_rfifo_rst,
	input  wire                          flush_i,
	input  wire frame_rd_pkg::beat_t     word_i,
	input  wire                          word_valid_i,
	input  wire                          pix_ready_i,
	output logic                         word_ready_o,
	output frame_rd_pkg::pix_t           pix_o,
	output logic                         pix_valid_o
);

	// lane of the head word that goes out next
	frame_rd_pkg::lane_t lane_q;
	logic last_lane;
	logic pix_fire;

	// ------------------------------
	// pixel stream
	// ------------------------------
	// no pixel leaves while the old frame is thrown away
	assign pix_valid_o = word_valid_i && !flush_i;
	assign pix_o = word_i[lane_q * frame_rd_pkg::pix_w +: frame_rd_pkg::pix_w];
	assign pix_fire = pix_valid_o && pix_ready_i;

	assign last_lane = lane_q == frame_rd_pkg::lane_t'(frame_rd_pkg::lanes - 1);
	// pop the word together with its top lane
	assign word_ready_o = pix_fire && last_lane;

	// ------------------------------
	// lane counter
	// ------------------------------
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			lane_q <= '0;
		end else if (flush_i) begin
			// a half sent word is dropped with the FIFO
			lane_q <= '0;
		end else if (pix_fire) begin
			if (last_lane) begin
				lane_q <= '0;
			end else begin
				lane_q <= lane_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/frame_reader_top.sv
// read side of the frame buffer, AXI4 read ports in and a 32-bit pixel stream out
`default_nettype none

module frame_reader_top (
	input  wire                          axi_clk,
	input  wire                          r_rfifo_rst,
	// frame window, static during a frame
	input  wire frame_rd_pkg::addr_t     base_addr_i,
	input  wire frame_rd_pkg::addr_t     end_addr_i,
	// new frame on the falling edge
	input  wire                          vsync_i,
	// AXI read address channel
	output wire frame_rd_pkg::axi_ar_t   ar_o,
	output wire                          arvalid_o,
	input  wire                          arready_i,
	// AXI read data channel
	input  wire frame_rd_pkg::axi_r_t    r_i,
	input  wire                          rvalid_i,
	output wire                          rready_o,
	// pixel stream
	output wire frame_rd_pkg::pix_t      pix_o,
	output wire                          pix_valid_o,
	input  wire                          pix_ready_i
);

	// reader to FIFO
	frame_rd_pkg::beat_t beat;
	logic beat_valid;
	logic flush;
	logic burst_room;
	// FIFO to unpacker
	frame_rd_pkg::beat_t word;
	logic word_valid;
	logic word_ready;

	// burst is only asked for when it fits, so data is never stalled
	assign rready_o = 1'b1;

	// ------------------------------
	// producer
	// ------------------------------
	axi_burst_reader u_reader (
		.axi_clk      (axi_clk),
		.r_rfifo_rst  (r_rfifo_rst),
		.base_addr_i  (base_addr_i),
		.end_addr_i   (end_addr_i),
		.vsync_i      (vsync_i),
		.arready_i    (arready_i),
		.r_i          (r_i),
		.rvalid_i     (rvalid_i),
		.burst_room_i (burst_room),
		.ar_o         (ar_o),
		.arvalid_o    (arvalid_o),
		.beat_o       (beat),
		.beat_valid_o (beat_valid),
		.flush_o      (flush)
	);

	// ------------------------------
	// line buffer
	// ------------------------------
	// watches the AR handshake to reserve space
	line_fifo u_fifo (
		.axi_clk      (axi_clk),
		.r_rfifo_rst  (r_rfifo_rst),
		.flush_i      (flush),
		.beat_i       (beat),
		.beat_valid_i (beat_valid),
		.word_ready_i (word_ready),
		.arvalid_i    (arvalid_o),
		.arready_i    (arready_i),
		.burst_room_o (burst_room),
		.word_o       (word),
		.word_valid_o (word_valid)
	);

	// ------------------------------
	// consumer
	// ------------------------------
	pixel_unpacker u_unpack (
		.axi_clk      (axi_clk),
		.r_rfifo_rst  (r_rfifo_rst),
		.flush_i      (flush),
		.word_i       (word),
		.word_valid_i (word_valid),
		.pix_ready_i  (pix_ready_i),
		.word_ready_o (word_ready),
		.pix_o        (pix_o),
		.pix_valid_o  (pix_valid_o)
	);

endmodule

`default_nettype wire

//--- bench/frame_reader_props.sv
// checker bound into the frame reader top, watches AR requests and the pixel stream
`default_nettype none

module frame_reader_props (
	input  wire                          axi_clk,
	input  wire                          r_rfifo_rst,
	input  wire frame_rd_pkg::addr_t     base_addr_i,
	input  wire frame_rd_pkg::addr_t     end_addr_i,
	input  wire                          vsync_i,
	input  wire frame_rd_pkg::axi_ar_t   ar_i,
	input  wire                          arvalid_i,
	input  wire                          arready_i,
	input  wire                          rready_i,
	input  wire frame_rd_pkg::pix_t      pix_i,
	input  wire                          pix_valid_i,
	input  wire                          pix_ready_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench to end the run
	int fail_cnt = 0;
	// next burst address and next pixel of the frame
	frame_rd_pkg::addr_t exp_addr;
	frame_rd_pkg::pix_t exp_pix;
	// cycles since the frame took hold, saturating
	int since_start;
	logic vsync_q;
	logic restart_q;
	logic arvalid_q;
	logic vsync_fall;
	logic launch;
	logic pix_fire;

	assign vsync_fall = vsync_q && !vsync_i;
	// one burst outstanding, so every rise of arvalid is a new request
	assign launch = arvalid_i && !arvalid_q;
	assign pix_fire = pix_valid_i && pix_ready_i;

	// ------------------------------
	// expected frame sequence
	// ------------------------------
	always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
		if (r_rfifo_rst) begin
			vsync_q <= 1'b0;
			restart_q <= 1'b0;
			arvalid_q <= 1'b0;
			since_start <= 0;
			exp_addr <= base_addr_i;
			exp_pix <= base_addr_i / 4;
		end else begin
			vsync_q <= vsync_i;
			restart_q <= vsync_fall;
			arvalid_q <= arvalid_i;
			if (since_start <= frame_rd_pkg::settle_cycles) begin
				since_start <= since_start + 1;
			end
			if (launch) begin
				exp_addr <= exp_addr + frame_rd_pkg::addr_t'(frame_rd_pkg::burst_bytes);
			end
			if (pix_fire) begin
				exp_pix <= exp_pix + 1'b1;
			end
			// new frame holds from the flush cycle on
			if (restart_q) begin
				since_start <= 0;
				exp_addr <= base_addr_i;
				exp_pix <= base_addr_i / 4;
			end
		end
	end

	// ------------------------------
	// assertions
	// ------------------------------
	ar_hold: assert property (@(posedge axi_clk) disable iff (r_rfifo_rst)
		arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
	else begin
		fail_cnt++;
		$error("AR request changed or dropped before arready at %0t", $time);
	end

	// next burst of the window, INCR, full length, never inside the settle time
	ar_next: assert property (@(posedge axi_clk) disable iff (r_rfifo_rst)
		launch |-> ar_i.addr == exp_addr && ar_i.addr < end_addr_i
			&& ar_i.len == 8'(frame_rd_pkg::burst_len - 1)
			&& ar_i.size == 3'(frame_rd_pkg::axi_size) && ar_i.burst == 2'b01
			&& since_start >= frame_rd_pkg::settle_cycles)
	else begin
		fail_cnt++;
		$error("mismatch at %0t: AR addr %h, expected %h, %0d cycles into frame", $time,
			$sampled(ar_i.addr), $sampled(exp_addr), $sampled(since_start));
	end

	// read data is always taken
	r_ready: assert property (@(posedge axi_clk) disable iff (r_rfifo_rst)
		rready_i)
	else begin
		fail_cnt++;
		$error("rready low at %0t, a read beat could be refused", $time);
	end

	// held under back-pressure unless the frame is thrown away
	pix_hold: assert property (@(posedge axi_clk) disable iff (r_rfifo_rst)
		pix_valid_i && !pix_ready_i && !vsync_fall |=> pix_valid_i && $stable(pix_i))
	else begin
		fail_cnt++;
		$error("pixel changed or dropped while stalled at %0t", $time);
	end

	pix_value: assert property (@(posedge axi_clk) disable iff (r_rfifo_rst)
		pix_fire |-> pix_i == exp_pix && pix_i < end_addr_i / 4)
	else begin
		fail_cnt++;
		$error("mismatch at %0t: pixel %h, expected %h", $time,
			$sampled(pix_i), $sampled(exp_pix));
	end

	reset_quiet: assert property (@(posedge axi_clk)
		r_rfifo_rst |-> !arvalid_i && !pix_valid_i)
	else begin
		fail_cnt++;
		$error("request or pixel valid during reset at %0t", $time);
	end

endmodule

bind frame_reader_top frame_reader_props u_props (
	.axi_clk     (axi_clk),
	.r_rfifo_rst (r_rfifo_rst),
	.base_addr_i (base_addr_i),
	.end_addr_i  (end_addr_i),
	.vsync_i     (vsync_i),
	.ar_i        (ar_o),
	.arvalid_i   (arvalid_o),
	.arready_i   (arready_i),
	.rready_i    (rready_o),
	.pix_i       (pix_o),
	.pix_valid_i (pix_valid_o),
	.pix_ready_i (pix_ready_i)
);

`default_nettype wire

//--- bench/frame_reader_tb.sv
// testbench for the frame reader, runs an AXI read slave, a stalling pixel sink and frame restarts
`default_nettype none

module frame_reader_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period = 8;
	localparam frame_rd_pkg::addr_t frame_base = 32'h0004_0000;
	// four bursts per frame
	localparam int window_bytes = 1024;
	localparam int frame_pixels = window_bytes / 4;
	localparam int watchdog_cycles = 3 * frame_pixels * 8 + 2000;

	logic axi_clk;
	logic r_rfifo_rst;
	frame_rd_pkg::addr_t base_addr;
	frame_rd_pkg::addr_t end_addr;
	logic vsync;
	frame_rd_pkg::axi_ar_t ar;
	logic arvalid;
	logic arready;
	frame_rd_pkg::axi_r_t r;
	logic rvalid;
	logic rready;
	frame_rd_pkg::pix_t pix;
	logic pix_valid;
	logic pix_ready;
	integer seed = 80;
	// pixels taken by the sink
	int pix_count;

	frame_reader_top u_dut (
		.axi_clk     (axi_clk),
		.r_rfifo_rst (r_rfifo_rst),
		.base_addr_i (base_addr),
		.end_addr_i  (end_addr),
		.vsync_i     (vsync),
		.ar_o        (ar),
		.arvalid_o   (arvalid),
		.arready_i   (arready),
		.r_i         (r),
		.rvalid_i    (rvalid),
		.rready_o    (rready),
		.pix_o       (pix),
		.pix_valid_o (pix_valid),
		.pix_ready_i (pix_ready)
	);

	// each 32-bit lane holds its own byte address divided by 4
	function automatic frame_rd_pkg::axi_r_t mem_beat(input frame_rd_pkg::addr_t addr,
		input logic last);
		frame_rd_pkg::axi_r_t beat;
		beat.resp = 2'b00;
		beat.last = last;
		for (int k = 0; k < 4; k++) begin
			beat.data[k * 32 +: 32] = addr / 4 + k;
		end
		return beat;
	endfunction

	// one INCR burst with random gaps on rvalid
	task automatic return_burst(input frame_rd_pkg::addr_t addr);
		int gap;
		for (int b = 0; b < frame_rd_pkg::burst_len; b++) begin
			gap = $unsigned($random(seed)) % 3;
			rvalid = 1'b0;
			repeat (gap) @(negedge axi_clk);
			r = mem_beat(addr + frame_rd_pkg::addr_t'(b * 16), b == frame_rd_pkg::burst_len - 1);
			rvalid = 1'b1;
			@(negedge axi_clk);
		end
		rvalid = 1'b0;
	endtask

	// vsync pulse, the new frame begins on its falling edge
	task automatic start_frame(output int start);
		vsync = 1'b1;
		repeat (4) @(negedge axi_clk);
		vsync = 1'b0;
		// last old-frame pixel already counted here
		@(negedge axi_clk);
		start = pix_count;
	endtask

	// ------------------------------
	// clock, slave and sink
	// ------------------------------
	initial begin : clock_gen
		axi_clk = 1'b0;
		forever begin
			#(clk_period / 2) axi_clk = ~axi_clk;
		end
	end

	initial begin : mem_model
		int delay;
		frame_rd_pkg::addr_t addr;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		forever begin
			@(negedge axi_clk);
			if (arvalid) begin
				delay = $unsigned($random(seed)) % 5;
				repeat (delay) @(negedge axi_clk);
				// request held while arvalid is up
				addr = ar.addr;
				arready = 1'b1;
				@(negedge axi_clk);
				arready = 1'b0;
				return_burst(addr);
			end
		end
	end

	initial begin : pixel_sink
		pix_ready = 1'b0;
		pix_count = 0;
		forever begin
			@(negedge axi_clk);
			pix_ready = ($unsigned($random(seed)) % 4) != 0;
			// transfer lands on the coming rising edge
			if (pix_valid && pix_ready) begin
				pix_count++;
			end
		end
	end

	// ------------------------------
	// run control
	// ------------------------------
	initial begin : fail_watch
		wait (u_dut.u_props.fail_cnt != 0);
		$display("test failed");
		$fatal(1, "the bound checker reported an assertion failure");
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		$display("test failed");
		$fatal(1, "timeout, the pixel stream did not finish within %0d cycles", watchdog_cycles);
	end

	initial begin : stimulus
		int start;
		r_rfifo_rst = 1'b1;
		base_addr = frame_base;
		end_addr = frame_base + window_bytes;
		vsync = 1'b0;
		repeat (5) @(posedge axi_clk);
		@(negedge axi_clk);
		r_rfifo_rst = 1'b0;
		// reset acts as a frame start
		wait (pix_count >= frame_pixels);
		repeat (64) @(negedge axi_clk);
		start_frame(start);
		wait (pix_count >= start + frame_pixels);
		repeat (64) @(negedge axi_clk);
		// restart in mid-frame, then a full frame
		start_frame(start);
		wait (pix_count >= start + 100);
		start_frame(start);
		wait (pix_count >= start + frame_pixels);
		repeat (64) @(negedge axi_clk);
		if (u_dut.u_props.fail_cnt == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "the bound checker reported an assertion failure");
		end
	end

endmodule

`default_nettype wire

//--- files.f
logic/frame_rd_pkg.sv
logic/axi_burst_reader.sv
logic/line_fifo.sv
logic/pixel_unpacker.sv
logic/frame_reader_top.sv
bench/frame_reader_props.sv
bench/frame_reader_tb.sv

//--- Makefile
TOP = frame_reader_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
